// File: mipsSystem.f
rtl/mipsPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/memArbiter.sv
rtl/unifiedMem.sv
rtl/coreCtrl.sv
rtl/mipsSystem.sv
verif/mipsSystemTb.sv

// File: rtl/alu.sv
/* 32-bit combinational ALU with add, sub, logic ops and signed
   set-less-than, plus a zero flag for branch compares */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  mipsPkg::wordT  a,
    input  mipsPkg::wordT  b,
    input  mipsPkg::aluOpT op,
    output mipsPkg::wordT  y,
    output logic           zero
);
    import mipsPkg::*;

    // Difference shared by sub and by the branch compare
    wordT diff;
    // Signed compare result for slt
    logic lessThan;

    assign diff = a - b;

    // Signed compare, negative operands order below positive ones
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            // Arithmetic group
            aluAdd: y = a + b;
            aluSub: y = diff;

            // Logic group
            aluAnd: y = a & b;
            aluOr:  y = a | b;
            aluXor: y = a ^ b;
            aluNor: y = ~(a | b);

            // Only bit 0 carries the compare result
            aluSlt: y = {31'b0, lessThan};

            // Unused encoding
            default: y = '0;
        endcase
    end

    // Zero flag, high for an all-zero result
    // beq runs sub through here, so zero means equal operands
    assign zero = ~|y;

endmodule

`default_nettype wire

// File: rtl/coreCtrl.sv
/* Multi-cycle MIPS subset controller: PC, instruction register, decode,
   ALU operand select, register writeback and memory requests */
`timescale 1ns/1ns
`default_nettype none

module coreCtrl #(
    parameter int MEMORY_WORDS = 256
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            start,
    output logic            halted,
    output mipsPkg::memReqT fetchReq,
    input  logic            fetchAck,
    output mipsPkg::memReqT dataReq,
    input  logic            dataAck,
    input  mipsPkg::wordT   memRdata,
    output logic [4:0]      rdAddrA,
    output logic [4:0]      rdAddrB,
    input  mipsPkg::wordT   rdDataA,
    input  mipsPkg::wordT   rdDataB,
    output logic            wrEn,
    output logic [4:0]      wrAddr,
    output mipsPkg::wordT   wrData,
    output mipsPkg::wordT   aluA,
    output mipsPkg::wordT   aluB,
    output mipsPkg::aluOpT  aluOp,
    input  mipsPkg::wordT   aluY,
    input  logic            aluZero
);
    import mipsPkg::*;

    coreStateT   state;
    // Word-addressed PC, already points past the instruction after decode
    logic [29:0] pc;
    logic [29:0] pcPlus1;
    logic [29:0] brTarget;
    wordT        ir;
    wordT        aluOut;
    wordT        immExt;
    opcodeT      opcode;
    functT       funct;
    logic        fetchValid;
    // Memory read granted last cycle, data is on memRdata now
    logic        rdPend;

    // Instruction fields
    assign opcode  = opcodeT'(ir[31:26]);
    assign funct   = functT'(ir[5:0]);
    assign immExt  = {{16{ir[15]}}, ir[15:0]};
    assign rdAddrA = ir[25:21];
    assign rdAddrB = ir[20:16];

    // PC arithmetic wraps at the memory depth
    assign pcPlus1  = (pc + 30'd1) % 30'(MEMORY_WORDS);
    // Offset in words, counted from the already incremented PC
    assign brTarget = (pc + immExt[29:0]) % 30'(MEMORY_WORDS);

    // ALU operation from opcode and function field
    always_comb begin
        aluOp = aluAdd;
        if (opcode == opBeq) begin
            aluOp = aluSub;
        end else if (opcode == opRType) begin
            case (funct)
                fnAdd:   aluOp = aluAdd;
                fnSub:   aluOp = aluSub;
                fnAnd:   aluOp = aluAnd;
                fnOr:    aluOp = aluOr;
                fnXor:   aluOp = aluXor;
                fnNor:   aluOp = aluNor;
                fnSlt:   aluOp = aluSlt;
                default: aluOp = aluAdd;
            endcase
        end
    end

    // rt is a source for R-type and beq, otherwise the immediate goes in
    assign aluA = rdDataA;
    assign aluB = (opcode == opRType || opcode == opBeq) ? rdDataB : immExt;

    // Writeback from the ALU, or straight from memory as a load returns
    assign wrEn   = (state == sWriteback) || (state == sMem && rdPend);
    assign wrAddr = (opcode == opRType) ? ir[15:11] : ir[20:16];
    assign wrData = (state == sMem) ? memRdata : aluOut;

    // Fetch always reads the word at the PC
    assign fetchReq = '{valid: fetchValid, we: 1'b0, addr: pc, wdata: '0};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= sIdle;
            pc         <= '0;
            fetchValid <= 1'b0;
            rdPend     <= 1'b0;
            dataReq    <= '0;
            halted     <= 1'b0;
        end else begin
            case (state)
                // Start restarts the program from word 0
                sIdle, sHalted: begin
                    if (start) begin
                        pc         <= '0;
                        fetchValid <= 1'b1;
                        halted     <= 1'b0;
                        state      <= sFetch;
                    end
                end
                // Hold the request until granted, then wait one cycle for data
                sFetch: begin
                    if (fetchAck) begin
                        fetchValid <= 1'b0;
                        rdPend     <= 1'b1;
                    end
                    if (rdPend) begin
                        rdPend <= 1'b0;
                        state  <= sDecode;
                    end
                end
                sDecode: begin
                    pc <= pcPlus1;
                    if (opcode == opHalt) begin
                        halted <= 1'b1;
                        state  <= sHalted;
                    end else begin
                        state <= sExecute;
                    end
                end
                sExecute: begin
                    case (opcode)
                        opRType, opAddi: state <= sWriteback;
                        // Byte address from base plus offset, word select in bits 31:2
                        opLw, opSw: begin
                            dataReq <= '{valid: 1'b1, we: (opcode == opSw),
                                         addr: aluY[31:2], wdata: rdDataB};
                            state   <= sMem;
                        end
                        opBeq: begin
                            if (aluZero) begin
                                pc <= brTarget;
                            end
                            fetchValid <= 1'b1;
                            state      <= sFetch;
                        end
                        // Unknown opcodes fall through as no-ops
                        default: begin
                            fetchValid <= 1'b1;
                            state      <= sFetch;
                        end
                    endcase
                end
                sMem: begin
                    if (dataAck) begin
                        dataReq.valid <= 1'b0;
                        if (dataReq.we) begin
                            fetchValid <= 1'b1;
                            state      <= sFetch;
                        end else begin
                            rdPend <= 1'b1;
                        end
                    end
                    // Load data written to rt this cycle
                    if (rdPend) begin
                        rdPend     <= 1'b0;
                        fetchValid <= 1'b1;
                        state      <= sFetch;
                    end
                end
                sWriteback: begin
                    fetchValid <= 1'b1;
                    state      <= sFetch;
                end
                default: state <= sIdle;
            endcase
        end
    end

    // Instruction and ALU result holding registers
    always_ff @(posedge clk) begin
        if (state == sFetch && rdPend) begin
            ir <= memRdata;
        end
        if (state == sExecute) begin
            aluOut <= aluY;
        end
    end

endmodule

`default_nettype wire

// File: rtl/memArbiter.sv
/* Fixed-priority memory arbiter for data, fetch and host requesters,
   one grant per cycle, and tracking of host read returns */
`timescale 1ns/1ns
`default_nettype none

module memArbiter (
    input  logic            clk,
    input  logic            arstN,
    input  mipsPkg::memReqT fetchReq,
    input  mipsPkg::memReqT dataReq,
    input  mipsPkg::memReqT hostReq,
    output logic            fetchAck,
    output logic            dataAck,
    output logic            hostAck,
    output mipsPkg::memReqT memReq,
    output logic            hostRdataValid
);

    logic grantData;
    logic grantFetch;
    logic grantHost;
    // Host owns the read data coming back next cycle
    logic hostRdOwner;

    // Data first, so a load or store never waits behind the next fetch
    assign grantData  = dataReq.valid;
    assign grantFetch = fetchReq.valid && !dataReq.valid;
    // Host only gets the cycles the core leaves free
    assign grantHost  = hostReq.valid && !dataReq.valid && !fetchReq.valid;

    // Ack in the same cycle the memory samples the request
    // Requester drops valid at that edge, so this is a single pulse
    assign dataAck  = grantData;
    assign fetchAck = grantFetch;
    assign hostAck  = grantHost;

    // Forward the winner, idle bus when nobody asks
    always_comb begin
        if (grantData) begin
            memReq = dataReq;
        end else if (grantFetch) begin
            memReq = fetchReq;
        end else if (grantHost) begin
            memReq = hostReq;
        end else begin
            memReq = '0;
        end
    end

    // Host writes return nothing, only reads mark the next cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hostRdOwner <= 1'b0;
        end else begin
            hostRdOwner <= grantHost && !hostReq.we;
        end
    end

    assign hostRdataValid = hostRdOwner;

endmodule

`default_nettype wire

// File: rtl/mipsPkg.sv
/* MIPS subset shared types: instruction encodings, ALU operations,
   control states and the memory request format */
`default_nettype none

package mipsPkg;

    // Data word as seen by registers, ALU and memory
    typedef logic [31:0] wordT;

    // Primary opcode field, bits 31:26 of the instruction
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2B,
        // Not a MIPS opcode, reserved here to stop the core
        opHalt  = 6'h3F
    } opcodeT;

    // R-type function field, bits 5:0, standard MIPS values
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnNor = 6'h27,
        fnSlt = 6'h2A
    } functT;

    // Operation select for the ALU
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluNor = 3'd5,
        aluSlt = 3'd6
    } aluOpT;

    // Multi-cycle sequencer states
    typedef enum logic [2:0] {
        sIdle,
        sFetch,
        sDecode,
        sExecute,
        sMem,
        sWriteback,
        sHalted
    } coreStateT;

    // One memory request, 64 bits in all
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [29:0] addr;   // Word address
        wordT        wdata;
    } memReqT;

endpackage

`default_nettype wire

// File: rtl/mipsSystem.sv
/* Multi-cycle MIPS subset system: core, register file, ALU, arbiter
   and unified memory, with a host port for loading and readback */
`timescale 1ns/1ns
`default_nettype none

module mipsSystem #(
    parameter int MEMORY_WORDS = 256
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            start,
    output logic            halted,
    input  mipsPkg::memReqT hostReq,
    output logic            hostAck,
    output mipsPkg::wordT   hostRdata,
    output logic            hostRdataValid
);
    import mipsPkg::*;

    // Memory side
    memReqT fetchReq;
    memReqT dataReq;
    memReqT memReq;
    logic   fetchAck;
    logic   dataAck;
    wordT   memRdata;

    // Register file side
    logic [4:0] rdAddrA;
    logic [4:0] rdAddrB;
    logic [4:0] wrAddr;
    wordT       rdDataA;
    wordT       rdDataB;
    wordT       wrData;
    logic       wrEn;

    // ALU side
    wordT  aluA;
    wordT  aluB;
    wordT  aluY;
    aluOpT aluOp;
    logic  aluZero;

    coreCtrl #(.MEMORY_WORDS(MEMORY_WORDS)) core (
        .clk(clk), .arstN(arstN), .start(start), .halted(halted),
        .fetchReq(fetchReq), .fetchAck(fetchAck),
        .dataReq(dataReq), .dataAck(dataAck), .memRdata(memRdata),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .aluA(aluA), .aluB(aluB), .aluOp(aluOp),
        .aluY(aluY), .aluZero(aluZero)
    );

    regFile regs (
        .clk(clk), .arstN(arstN),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    alu aluUnit (.a(aluA), .b(aluB), .op(aluOp), .y(aluY), .zero(aluZero));

    memArbiter arb (
        .clk(clk), .arstN(arstN),
        .fetchReq(fetchReq), .dataReq(dataReq), .hostReq(hostReq),
        .fetchAck(fetchAck), .dataAck(dataAck), .hostAck(hostAck),
        .memReq(memReq), .hostRdataValid(hostRdataValid)
    );

    unifiedMem #(.MEMORY_WORDS(MEMORY_WORDS)) mem (
        .clk(clk), .memReq(memReq), .rdata(memRdata)
    );

    // Host shares the read bus with the core, hostRdataValid marks its words
    assign hostRdata = memRdata;

endmodule

`default_nettype wire

// File: rtl/regFile.sv
/* Thirty-two entry register file, two async read ports and one
   synchronous write port, register zero reads as zero */
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic          clk,
    input  logic          arstN,
    input  logic [4:0]    rdAddrA,
    input  logic [4:0]    rdAddrB,
    output mipsPkg::wordT rdDataA,
    output mipsPkg::wordT rdDataB,
    input  logic          wrEn,
    input  logic [4:0]    wrAddr,
    input  mipsPkg::wordT wrData
);
    import mipsPkg::*;

    // Register array, index fixed by the 5-bit ISA field
    wordT regs [32];

    // Write lands at the clock edge
    // Register zero is never written, so it stays at its reset value
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Combinational reads
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

// File: rtl/unifiedMem.sv
/* Single-port synchronous word memory shared by instructions and data */
`timescale 1ns/1ns
`default_nettype none

module unifiedMem #(
    parameter int MEMORY_WORDS = 256
) (
    input  logic            clk,
    input  mipsPkg::memReqT memReq,
    output mipsPkg::wordT   rdata
);
    import mipsPkg::*;

    localparam int ADDR_W = $clog2(MEMORY_WORDS);

    // Word storage, no reset, host loads it before a run
    wordT mem [MEMORY_WORDS];

    // Array index after folding the address into the depth
    logic [ADDR_W-1:0] wordIdx;

    // Addresses beyond the depth wrap around
    assign wordIdx = ADDR_W'(memReq.addr % 30'(MEMORY_WORDS));

    // One access per cycle
    // Read data shows up on rdata the cycle after the request
    always_ff @(posedge clk) begin
        if (memReq.valid) begin
            if (memReq.we) begin
                mem[wordIdx] <= memReq.wdata;
            end else begin
                rdata <= mem[wordIdx];
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench and RTL with Verilator, run it, and look for the pass line
verilator --binary -j 0 --timescale 1ns/1ns --top-module mipsSystemTb \
    -f mipsSystem.f -o mipsSystemSim &&
    out="$(./obj_dir/mipsSystemSim)" &&
    echo "$out" &&
    echo "$out" | grep -q "Regression passed" ||
    { echo "run.sh: simulation did not pass"; exit 1; }

// File: verif/mipsSystemTb.sv
/* Testbench for the multi-cycle MIPS subset system: loads programs over the
   host port, runs them and checks memory results against an ISA model */
`timescale 1ns/1ns
`default_nettype none

module mipsSystemTb;
    import mipsPkg::*;

    localparam int MEM_WORDS = 256;
    localparam int ADDR_W = $clog2(MEM_WORDS);
    // Word addresses of the operand, result and scratch areas
    localparam int OPND_BASE = 128;
    localparam int RES_BASE = 160;
    localparam int SCRATCH = 190;
    localparam int ACK_TIMEOUT = 2000;
    localparam int HALT_TIMEOUT = 20000;
    localparam int REF_STEP_LIMIT = 10000;

    logic   clk;
    logic   arstN;
    logic   start;
    logic   halted;
    memReqT hostReq;
    logic   hostAck;
    wordT   hostRdata;
    logic   hostRdataValid;

    // Testbench copy of memory and registers for the ISA model
    wordT refMem [MEM_WORDS];
    wordT refRegs [32];
    wordT prog [MEM_WORDS];
    int   progLen;
    int   resCount;
    wordT lcgState;
    // Expected host read data, consumed by the compare process
    wordT  expQ [$];
    string nameQ [$];
    int   errCount;
    int   errAtStart;
    int   testsRun;
    int   testsFailed;
    logic ackWhileBusy;

    mipsSystem #(.MEMORY_WORDS(MEM_WORDS)) UUT (
        .clk(clk), .arstN(arstN), .start(start), .halted(halted),
        .hostReq(hostReq), .hostAck(hostAck),
        .hostRdata(hostRdata), .hostRdataValid(hostRdataValid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic wordT nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic wordT encR(int rs, int rt, int rd, functT fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic wordT encI(opcodeT op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // ISA model, runs from word 0 until halt, returns steps or 0 on runaway
    function automatic int runReference();
        wordT pcW;
        wordT ins;
        wordT a;
        wordT b;
        wordT res;
        wordT imm;
        logic [ADDR_W-1:0] dIdx;
        pcW = '0;
        for (int steps = 1; steps <= REF_STEP_LIMIT; steps++) begin
            ins = refMem[ADDR_W'(pcW % MEM_WORDS)];
            pcW = pcW + 32'd1;
            a = refRegs[ins[25:21]];
            b = refRegs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            // Byte address to word index, wrapped at the depth
            dIdx = ADDR_W'(((a + imm) >> 2) % MEM_WORDS);
            case (ins[31:26])
                opRType: begin
                    case (ins[5:0])
                        fnSub:   res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnXor:   res = a ^ b;
                        fnNor:   res = ~(a | b);
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = a + b;
                    endcase
                    if (ins[15:11] != 5'd0) refRegs[ins[15:11]] = res;
                end
                opAddi: if (ins[20:16] != 5'd0) refRegs[ins[20:16]] = a + imm;
                opLw:   if (ins[20:16] != 5'd0) refRegs[ins[20:16]] = refMem[dIdx];
                opSw:   refMem[dIdx] = b;
                opBeq:  if (a == b) pcW = pcW + imm;
                opHalt: return steps;
                default: ;
            endcase
        end
        return 0;
    endfunction

    task automatic checkValue(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Regression failed");
        $finish;
    endtask

    task automatic finishTest(string name);
        testsRun++;
        if (errCount == errAtStart) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            $display("test %0d %s: FAILED", testsRun, name);
            testsFailed++;
        end
        errAtStart = errCount;
    endtask

    // One host access, entered and left 2 ns after a rising edge
    task automatic hostAccess(logic we, int addr, wordT wdata);
        int waitCycles;
        hostReq = '{valid: 1'b1, we: we, addr: 30'(addr), wdata: wdata};
        waitCycles = 0;
        @(negedge clk);
        while (!hostAck) begin
            waitCycles++;
            if (waitCycles > ACK_TIMEOUT) abortRun("host request was never acknowledged");
            @(negedge clk);
        end
        if (!halted) ackWhileBusy = 1'b1;
        @(posedge clk);
        #2;
        hostReq = '0;
        if (!we) begin
            @(negedge clk);
            if (!hostRdataValid) begin
                $display("host read at word %0d returned no valid data", addr);
                errCount++;
                void'(expQ.pop_front());
                void'(nameQ.pop_front());
            end
            // Let the compare process see the data before returning
            @(posedge clk);
            #2;
        end
    endtask

    task automatic readAndExpect(int addr, wordT exp);
        expQ.push_back(exp);
        nameQ.push_back($sformatf("hostRdata[%0d]", addr));
        hostAccess(1'b0, addr, '0);
    endtask

    task automatic writeBoth(int addr, wordT data);
        hostAccess(1'b1, addr, data);
        refMem[addr] = data;
    endtask

    // Tag the result and scratch words so a missing store shows up
    task automatic markResults();
        for (int k = RES_BASE; k <= SCRATCH; k++) begin
            writeBoth(k, 32'hC0DE_0000 | 32'(k));
        end
    endtask

    task automatic startCore();
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        @(negedge clk);
        checkValue("halted", {31'b0, halted}, 32'd0);
        @(posedge clk);
        #2;
    endtask

    task automatic waitHalted();
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        while (!halted) begin
            waitCycles++;
            if (waitCycles > HALT_TIMEOUT) abortRun("core did not halt in time");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic checkResults(int first, int last);
        for (int k = first; k <= last; k++) begin
            readAndExpect(RES_BASE + k, refMem[RES_BASE + k]);
        end
    endtask

    task automatic emit(wordT ins);
        prog[progLen] = ins;
        progLen++;
    endtask

    task automatic storeResult(int rt);
        emit(encI(opSw, 0, rt, (RES_BASE + resCount) * 4));
        resCount++;
    endtask

    task automatic buildProgram(int loopN);
        int loopTop;
        progLen = 0;
        resCount = 0;
        emit(encI(opLw, 0, 1, OPND_BASE * 4));
        emit(encI(opLw, 0, 2, OPND_BASE * 4 + 4));
        emit(encI(opLw, 0, 3, OPND_BASE * 4 + 8));
        // Results 0 to 8, R-type group with signed compares
        emit(encR(1, 2, 4, fnAdd));
        storeResult(4);
        emit(encR(1, 2, 4, fnSub));
        storeResult(4);
        emit(encR(1, 2, 4, fnAnd));
        storeResult(4);
        emit(encR(1, 2, 4, fnOr));
        storeResult(4);
        emit(encR(1, 2, 4, fnXor));
        storeResult(4);
        emit(encR(1, 2, 4, fnNor));
        storeResult(4);
        emit(encR(3, 1, 4, fnSlt));
        storeResult(4);
        emit(encR(1, 3, 4, fnSlt));
        storeResult(4);
        emit(encR(3, 2, 4, fnSlt));
        storeResult(4);
        // Results 9 to 11, negative immediates and store then load
        emit(encI(opAddi, 1, 5, -7));
        storeResult(5);
        emit(encI(opAddi, 0, 6, -100));
        storeResult(6);
        emit(encI(opSw, 0, 6, SCRATCH * 4));
        emit(encI(opLw, 0, 7, SCRATCH * 4));
        storeResult(7);
        // Result 12, countdown loop, exit branch taken on zero
        emit(encI(opAddi, 0, 8, loopN));
        emit(encI(opAddi, 0, 9, 0));
        loopTop = progLen;
        emit(encI(opAddi, 9, 9, 1));
        emit(encI(opAddi, 8, 8, -1));
        emit(encI(opBeq, 8, 0, 1));
        emit(encI(opBeq, 0, 0, loopTop - (progLen + 1)));
        storeResult(9);
        // Result 13 after a fall-through, result 14 after a taken skip
        emit(encI(opAddi, 0, 10, 5));
        emit(encI(opBeq, 1, 2, 1));
        emit(encI(opAddi, 10, 10, 3));
        storeResult(10);
        emit(encI(opBeq, 1, 1, 1));
        emit(encI(opAddi, 10, 10, 100));
        storeResult(10);
        emit({opHalt, 26'd0});
    endtask

    // Compare process for every word returned on the host port
    always @(negedge clk) begin
        if (hostRdataValid) begin
            if (expQ.size() == 0) begin
                $display("host read data arrived with no read outstanding");
                errCount++;
            end else begin
                checkValue(nameQ.pop_front(), hostRdata, expQ.pop_front());
            end
        end
    end

    initial begin
        wordT hostWords [8];
        wordT opA;
        wordT opB;
        wordT opNeg;
        int   loopN;
        arstN = 1'b0;
        start = 1'b0;
        hostReq = '0;
        lcgState = 32'd60;
        errCount = 0;
        errAtStart = 0;
        testsRun = 0;
        testsFailed = 0;
        ackWhileBusy = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) refMem[i] = '0;
        for (int i = 0; i < 32; i++) refRegs[i] = '0;
        repeat (4) @(posedge clk);
        #2;
        arstN = 1'b1;
        @(posedge clk);
        #2;

        // Plain host writes then reads
        for (int i = 0; i < 8; i++) begin
            hostWords[i] = nextRandom();
            hostAccess(1'b1, 200 + i, hostWords[i]);
        end
        for (int i = 0; i < 8; i++) readAndExpect(200 + i, hostWords[i]);
        finishTest("host write and read");

        // Positive, arbitrary and negative operands, A and B kept distinct
        opA = nextRandom();
        opA[31] = 1'b0;
        opB = nextRandom();
        if (opB == opA) opB = ~opA;
        opNeg = nextRandom();
        opNeg[31] = 1'b1;
        loopN = int'(nextRandom() % 32'd7) + 2;
        buildProgram(loopN);
        writeBoth(OPND_BASE, opA);
        writeBoth(OPND_BASE + 1, opB);
        writeBoth(OPND_BASE + 2, opNeg);
        for (int i = 0; i < progLen; i++) writeBoth(i, prog[i]);
        markResults();
        if (runReference() == 0) abortRun("reference model did not reach halt");
        startCore();
        waitHalted();
        checkResults(0, 8);
        finishTest("R-type ALU ops");

        checkResults(9, 11);
        finishTest("addi and store then load");

        checkResults(12, 14);
        finishTest("beq loop and branches");

        // Second run from word 0 with registers left from the first
        markResults();
        if (runReference() == 0) abortRun("reference model did not reach halt");
        startCore();
        waitHalted();
        checkResults(0, 14);
        finishTest("halt and restart");

        // Host reads contend with fetch and data traffic
        ackWhileBusy = 1'b0;
        markResults();
        if (runReference() == 0) abortRun("reference model did not reach halt");
        startCore();
        for (int i = 0; i < 3; i++) readAndExpect(OPND_BASE + i, refMem[OPND_BASE + i]);
        for (int i = 0; i < 4; i++) readAndExpect(i, refMem[i]);
        waitHalted();
        checkValue("hostAckWhileRunning", {31'b0, ackWhileBusy}, 32'd1);
        checkResults(12, 12);
        finishTest("host reads during run");

        $display("tests %0d, failed %0d, check errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
